/* rtl/stat_params.svh */
// Statistics hub widths, counts, counter address map and runt threshold
`ifndef STAT_PARAMS_SVH
`define STAT_PARAMS_SVH

// Monitored receive ports and counters kept for each
`define STAT_PORTS     2
`define STAT_PER_PORT  4

// Counter address and data widths
`define STAT_ADDR_W    3
`define STAT_CNT_W     32

// Frame length field, saturates at its maximum
`define STAT_LEN_W     16

// Frames below this many bytes count as runts
`define MIN_FRAME_LEN  64

// Counter index within a port, address = port * STAT_PER_PORT + index
`define STAT_IDX_FRAMES 0
`define STAT_IDX_BYTES  1
`define STAT_IDX_BAD    2
`define STAT_IDX_RUNT   3

`endif

/* rtl/stat_pkg.sv */
// Statistics hub package with the receive beat, frame record and read port types
`include "stat_params.svh"

package stat_pkg;

    // One GMII receive beat
    typedef struct packed {
        logic [7:0] rxd;
        logic       rx_dv;
        logic       rx_er;
    } gmii_rx_t;

    // One finished frame as seen by a monitor
    typedef struct packed {
        logic [`STAT_LEN_W-1:0] len;
        logic                   bad;
        logic                   runt;
    } frame_rec_t;

    // Frame record tagged with the port it came from
    typedef struct packed {
        logic [$clog2(`STAT_PORTS)-1:0] port;
        frame_rec_t                     rec;
    } port_rec_t;

    // Host read port, four-phase req/ack
    typedef struct packed {
        logic                    req;
        logic [`STAT_ADDR_W-1:0] addr;
    } rd_req_t;

    typedef struct packed {
        logic                   ack;
        logic [`STAT_CNT_W-1:0] data;
    } rd_rsp_t;

endpackage

/* rtl/port_stat_monitor.sv */
// Receive port monitor, measures each GMII frame and emits one record per frame
`timescale 1ns/1ns
`include "stat_params.svh"

module port_stat_monitor (
    input  logic                  clk,
    input  logic                  rst_n,

    // GMII receive beat
    input  stat_pkg::gmii_rx_t    gmii,

    // Record output, valid/ready
    output logic                  rec_valid,
    output stat_pkg::frame_rec_t  rec,
    input  logic                  rec_ready
);

localparam int LEN_W = `STAT_LEN_W;
localparam logic [LEN_W-1:0] LEN_MAX = '1;
localparam logic [LEN_W-1:0] RUNT_LEN = LEN_W'(`MIN_FRAME_LEN);

logic             in_frame;
logic [LEN_W-1:0] len_cnt;
logic             err_seen;
logic             frame_end;
logic             pending;
logic             load;

// First beat with rx_dv low after a frame
assign frame_end = in_frame && !gmii.rx_dv;

// Previous record not yet taken by the arbiter
assign pending = rec_valid && !rec_ready;

// A frame ending on top of a pending record is dropped
assign load = frame_end && !pending;

always_ff @(posedge clk) begin
    if (!rst_n) begin
        in_frame <= 1'b0;
        len_cnt  <= '0;
        err_seen <= 1'b0;
    end else begin
        in_frame <= gmii.rx_dv;
        if (gmii.rx_dv) begin
            if (!in_frame) begin
                // Start of frame
                len_cnt  <= LEN_W'(1);
                err_seen <= gmii.rx_er;
            end else begin
                if (len_cnt != LEN_MAX) begin
                    len_cnt <= len_cnt + 1'b1;
                end
                err_seen <= err_seen | gmii.rx_er;
            end
        end
    end
end

// Valid holds until the transfer, reloads if a new frame ends on that edge
always_ff @(posedge clk) begin
    if (!rst_n) begin
        rec_valid <= 1'b0;
    end else begin
        rec_valid <= load || pending;
    end
end

always_ff @(posedge clk) begin
    if (load) begin
        rec <= '{len: len_cnt, bad: err_seen, runt: len_cnt < RUNT_LEN};
    end
end

endmodule

/* rtl/stat_arbiter.sv */
// Round-robin arbiter, merges per-port frame records into one tagged update stream
`timescale 1ns/1ns
`include "stat_params.svh"

module stat_arbiter (
    input  logic                  clk,
    input  logic                  rst_n,

    // Per-port record inputs
    input  logic [`STAT_PORTS-1:0] in_valid,
    input  stat_pkg::frame_rec_t   in_rec [`STAT_PORTS],
    output logic [`STAT_PORTS-1:0] in_ready,

    // Tagged update toward the counter bank
    output logic                   upd_valid,
    output stat_pkg::port_rec_t    upd
);

localparam int N = `STAT_PORTS;
localparam int PW = $clog2(N);

logic [PW-1:0] last_grant;
logic [N-1:0]  grant;
logic [PW-1:0] grant_idx;
logic          grant_any;

// Search starts at the port after the last grant
always_comb begin
    int idx;
    grant     = '0;
    grant_idx = '0;
    grant_any = 1'b0;
    for (int k = 1; k <= N; k++) begin
        idx = (int'(last_grant) + k) % N;
        if (!grant_any && in_valid[idx]) begin
            grant_any      = 1'b1;
            grant[idx]     = 1'b1;
            grant_idx      = PW'(idx);
        end
    end
end

// Only the granted port sees ready
assign in_ready = grant;

always_ff @(posedge clk) begin
    if (!rst_n) begin
        upd_valid  <= 1'b0;
        // Port 0 wins the first contention
        last_grant <= PW'(N - 1);
    end else begin
        upd_valid <= grant_any;
        if (grant_any) begin
            last_grant <= grant_idx;
        end
    end
end

always_ff @(posedge clk) begin
    if (grant_any) begin
        upd <= '{port: grant_idx, rec: in_rec[grant_idx]};
    end
end

endmodule

/* rtl/stat_counter_bank.sv */
// Counter bank, accumulates frame records per port and serves four-phase host reads
`timescale 1ns/1ns
`include "stat_params.svh"

module stat_counter_bank (
    input  logic                 clk,
    input  logic                 rst_n,

    // Tagged update from the arbiter, always accepted
    input  logic                 upd_valid,
    input  stat_pkg::port_rec_t  upd,

    // Host read port
    input  stat_pkg::rd_req_t    rd,
    output stat_pkg::rd_rsp_t    rsp
);

localparam int CNT_W = `STAT_CNT_W;
localparam int ADDR_W = `STAT_ADDR_W;
localparam int NCNT = `STAT_PORTS * `STAT_PER_PORT;

typedef enum logic {
    RD_IDLE,
    // Ack raised, held until req drops
    RD_ACKED
} rd_state_t;

logic [CNT_W-1:0]  cnt [NCNT];
logic [ADDR_W-1:0] base;
logic [ADDR_W-1:0] a_frames;
logic [ADDR_W-1:0] a_bytes;
logic [ADDR_W-1:0] a_bad;
logic [ADDR_W-1:0] a_runt;
rd_state_t         rd_state;
logic [CNT_W-1:0]  rd_data;

// First counter of the updating port
assign base = ADDR_W'(upd.port * `STAT_PER_PORT);

assign a_frames = base + ADDR_W'(`STAT_IDX_FRAMES);
assign a_bytes  = base + ADDR_W'(`STAT_IDX_BYTES);
assign a_bad    = base + ADDR_W'(`STAT_IDX_BAD);
assign a_runt   = base + ADDR_W'(`STAT_IDX_RUNT);

// Counters wrap on overflow
always_ff @(posedge clk) begin
    if (!rst_n) begin
        for (int a = 0; a < NCNT; a++) begin
            cnt[a] <= '0;
        end
    end else if (upd_valid) begin
        cnt[a_frames] <= cnt[a_frames] + 1'b1;
        cnt[a_bytes]  <= cnt[a_bytes] + CNT_W'(upd.rec.len);
        cnt[a_bad]    <= cnt[a_bad] + CNT_W'(upd.rec.bad);
        cnt[a_runt]   <= cnt[a_runt] + CNT_W'(upd.rec.runt);
    end
end

// Four-phase read handshake
always_ff @(posedge clk) begin
    if (!rst_n) begin
        rd_state <= RD_IDLE;
    end else begin
        case (rd_state)
            RD_IDLE: begin
                if (rd.req) begin
                    rd_state <= RD_ACKED;
                end
            end
            RD_ACKED: begin
                if (!rd.req) begin
                    rd_state <= RD_IDLE;
                end
            end
        endcase
    end
end

// Sampled once per request so data stays stable while ack is high
always_ff @(posedge clk) begin
    if (rd_state == RD_IDLE && rd.req) begin
        rd_data <= cnt[rd.addr];
    end
end

assign rsp = '{ack: rd_state == RD_ACKED, data: rd_data};

endmodule

/* rtl/stat_hub.sv */
// Receive statistics hub, two port monitors merged into one per-port counter bank
`timescale 1ns/1ns
`include "stat_params.svh"

module stat_hub (
    input  logic                clk,
    input  logic                rst_n,

    // GMII receive ports
    input  stat_pkg::gmii_rx_t  gmii0,
    input  stat_pkg::gmii_rx_t  gmii1,

    // Host read port
    input  stat_pkg::rd_req_t   rd,
    output stat_pkg::rd_rsp_t   rsp
);

// Monitor to arbiter
logic [`STAT_PORTS-1:0] mon_valid;
logic [`STAT_PORTS-1:0] mon_ready;
stat_pkg::frame_rec_t   mon_rec [`STAT_PORTS];

// Arbiter to counter bank
logic                   upd_valid;
stat_pkg::port_rec_t    upd;

port_stat_monitor monitor0_inst (
    .clk(clk),
    .rst_n(rst_n),
    .gmii(gmii0),
    .rec_valid(mon_valid[0]),
    .rec(mon_rec[0]),
    .rec_ready(mon_ready[0])
);

port_stat_monitor monitor1_inst (
    .clk(clk),
    .rst_n(rst_n),
    .gmii(gmii1),
    .rec_valid(mon_valid[1]),
    .rec(mon_rec[1]),
    .rec_ready(mon_ready[1])
);

stat_arbiter arbiter_inst (
    .clk(clk),
    .rst_n(rst_n),
    .in_valid(mon_valid),
    .in_rec(mon_rec),
    .in_ready(mon_ready),
    .upd_valid(upd_valid),
    .upd(upd)
);

stat_counter_bank counter_bank_inst (
    .clk(clk),
    .rst_n(rst_n),
    .upd_valid(upd_valid),
    .upd(upd),
    .rd(rd),
    .rsp(rsp)
);

endmodule

/* sim/tb_stat_hub.sv */
// Testbench for the statistics hub, table-driven frames checked against a counter model
`timescale 1ns/1ns
`include "stat_params.svh"

module tb_stat_hub;

localparam int NCNT = `STAT_PORTS * `STAT_PER_PORT;
localparam int ADDR_W = `STAT_ADDR_W;
localparam int CNT_W = `STAT_CNT_W;
localparam int NROWS = 14;
localparam int GAP_CYCLES = 12;
localparam int ACK_TIMEOUT = 20;
localparam int HOLD_CYCLES = 6;

// One stimulus row: sending ports, frame length, rx_er on one beat
typedef struct packed {
    logic [1:0]  mask;
    logic [15:0] len;
    logic        err;
} row_t;

// Short frame whose counter update lands while a read holds ack
localparam row_t OVERLAP_ROW = '{2'b01, 16'd2, 1'b0};

logic                clk;
logic                rst_n;
stat_pkg::gmii_rx_t  gmii0;
stat_pkg::gmii_rx_t  gmii1;
stat_pkg::rd_req_t   rd;
stat_pkg::rd_rsp_t   rsp;

integer              seed;
logic [CNT_W-1:0]    model [NCNT];
logic [CNT_W-1:0]    overlap_data;

row_t table_rows [NROWS] = '{
    '{2'b01, 16'd64,   1'b0},
    '{2'b01, 16'd100,  1'b0},
    '{2'b01, 16'd1518, 1'b0},
    '{2'b10, 16'd64,   1'b0},
    '{2'b10, 16'd100,  1'b0},
    '{2'b10, 16'd1518, 1'b0},
    // Runts, the 2-byte frame is the shortest sent
    '{2'b01, 16'd63,   1'b0},
    '{2'b10, 16'd2,    1'b0},
    '{2'b01, 16'd40,   1'b0},
    // Bad frames
    '{2'b10, 16'd200,  1'b1},
    '{2'b01, 16'd64,   1'b1},
    // Both ports end on the same cycle
    '{2'b11, 16'd80,   1'b0},
    '{2'b11, 16'd30,   1'b1},
    '{2'b11, 16'd1518, 1'b0}
};

stat_hub i_dut (
    .clk(clk),
    .rst_n(rst_n),
    .gmii0(gmii0),
    .gmii1(gmii1),
    .rd(rd),
    .rsp(rsp)
);

initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
end

task automatic abort_run;
    $display("Simulation FAILED");
    $fatal(1, "Run stopped at the first failure");
endtask

task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                           input string what);
    if (actual !== expected) begin
        $display("** Error at %0t ns: %s, got %0d, expected %0d",
                 $time, what, actual, expected);
        abort_run();
    end
endtask

// Four-phase read, checks ack and data hold while req stays high
task automatic read_counter(input int addr, output logic [CNT_W-1:0] data);
    int               waited;
    logic [CNT_W-1:0] held;
    @(posedge clk);
    rd <= '{req: 1'b1, addr: ADDR_W'(addr)};
    waited = 0;
    @(posedge clk);
    while (!rsp.ack) begin
        if (waited == ACK_TIMEOUT) begin
            $display("Read of counter %0d: ack did not rise within %0d cycles",
                     addr, ACK_TIMEOUT);
            abort_run();
        end
        waited++;
        @(posedge clk);
    end
    held = rsp.data;
    repeat (HOLD_CYCLES) begin
        @(posedge clk);
        check_value(32'(rsp.ack), 32'd1, $sformatf("ack high while req high, counter %0d", addr));
        check_value(rsp.data, held, $sformatf("data stable while ack high, counter %0d", addr));
    end
    rd <= '{req: 1'b0, addr: ADDR_W'(addr)};
    waited = 0;
    @(posedge clk);
    while (rsp.ack) begin
        if (waited == ACK_TIMEOUT) begin
            $display("Read of counter %0d: ack did not fall within %0d cycles after req",
                     addr, ACK_TIMEOUT);
            abort_run();
        end
        waited++;
        @(posedge clk);
    end
    data = held;
endtask

// One frame on the masked ports, then the idle gap
task automatic send_frame(input row_t row);
    int                 len;
    int                 err_beat;
    stat_pkg::gmii_rx_t beat;
    len = int'(row.len);
    err_beat = len / 2;
    for (int b = 0; b < len; b++) begin
        @(posedge clk);
        beat.rx_dv = 1'b1;
        beat.rx_er = row.err && (b == err_beat);
        beat.rxd = 8'($random(seed));
        if (row.mask[0]) begin
            gmii0 <= beat;
        end else begin
            gmii0 <= '0;
        end
        beat.rxd = 8'($random(seed));
        if (row.mask[1]) begin
            gmii1 <= beat;
        end else begin
            gmii1 <= '0;
        end
    end
    @(posedge clk);
    gmii0 <= '0;
    gmii1 <= '0;
    // Gap is well past the 5-cycle path to the counters
    repeat (GAP_CYCLES - 1) @(posedge clk);
endtask

task automatic update_model(input row_t row);
    int base;
    for (int p = 0; p < `STAT_PORTS; p++) begin
        if (row.mask[p]) begin
            base = p * `STAT_PER_PORT;
            model[base + `STAT_IDX_FRAMES] = model[base + `STAT_IDX_FRAMES] + 32'd1;
            model[base + `STAT_IDX_BYTES] = model[base + `STAT_IDX_BYTES] + 32'(row.len);
            if (row.err) begin
                model[base + `STAT_IDX_BAD] = model[base + `STAT_IDX_BAD] + 32'd1;
            end
            if (int'(row.len) < `MIN_FRAME_LEN) begin
                model[base + `STAT_IDX_RUNT] = model[base + `STAT_IDX_RUNT] + 32'd1;
            end
        end
    end
endtask

task automatic check_all_counters(input string stage);
    logic [CNT_W-1:0] data;
    for (int a = 0; a < NCNT; a++) begin
        read_counter(a, data);
        check_value(data, model[a], $sformatf("counter %0d %s", a, stage));
    end
endtask

initial begin
    seed = 32'hbcc5_ee25;
    rst_n <= 1'b0;
    gmii0 <= '0;
    gmii1 <= '0;
    rd <= '0;
    for (int a = 0; a < NCNT; a++) begin
        model[a] = '0;
    end
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    check_all_counters("after reset");
    for (int r = 0; r < NROWS; r++) begin
        send_frame(table_rows[r]);
        update_model(table_rows[r]);
        check_all_counters($sformatf("after row %0d", r));
    end
    // Counter 0 changes while this read holds ack
    fork
        send_frame(OVERLAP_ROW);
        read_counter(0, overlap_data);
    join
    check_value(overlap_data, model[0], "counter 0 sampled when req rose");
    update_model(OVERLAP_ROW);
    check_all_counters("after read overlapping a frame");
    $display("Simulation PASSED");
    $finish;
end

endmodule

/* stat_hub.f */
+incdir+rtl
rtl/stat_pkg.sv
rtl/port_stat_monitor.sv
rtl/stat_arbiter.sv
rtl/stat_counter_bank.sv
rtl/stat_hub.sv
sim/tb_stat_hub.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the statistics hub testbench with Verilator and run it
# Warnings are still printed, they only do not stop the build

cd "$(dirname "$0")" &&
verilator --binary -Wno-fatal --top-module tb_stat_hub -f stat_hub.f -o tb_stat_hub_sim &&
./obj_dir/tb_stat_hub_sim | tee /dev/stderr | grep "Simulation PASSED" > /dev/null &&
echo "run_sim: testbench run succeeded" ||
{
    echo "run_sim: build or simulation failed"
    exit 1
}
